//--- source/mem_stage_pkg.sv
package mem_stage_pkg;

    // ******************************************************************
    // widths
    // ******************************************************************

    // data path width
    localparam int XLEN     = 64;
    // one strobe per byte lane
    localparam int STRB_W   = 8;
    localparam int BYTE_W   = XLEN / STRB_W;
    // byte offset inside a 64-bit word
    localparam int OFFSET_W = 3;
    localparam int REG_ID_W = 5;

    // link address step for jal / jalr
    localparam logic [XLEN-1:0] LINK_STEP = 64'd4;

    // ******************************************************************
    // operation codes
    // ******************************************************************

    // memory operation carried from execute
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LD   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_LHU  = 4'd6,
        MEM_LWU  = 4'd7,
        MEM_SB   = 4'd8,
        MEM_SH   = 4'd9,
        MEM_SW   = 4'd10,
        MEM_SD   = 4'd11
    } mem_op_t;

    // source of the register write-back value
    typedef enum logic [2:0] {
        WB_NONE = 3'd0,
        WB_ALU  = 3'd1,
        WB_LINK = 3'd2,
        WB_LOAD = 3'd3,
        WB_CSR  = 3'd4
    } wb_sel_t;

    // ******************************************************************
    // payloads
    // ******************************************************************

    // step one, straight from execute
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        mem_op_t         op;
        wb_sel_t         wb_sel;
        logic [XLEN-1:0] alu_result;
        logic [XLEN-1:0] src2;
    } ex_entry_t;

    // step two, waiting on ram read data
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [31:0]         inst;
        mem_op_t             op;
        wb_sel_t             wb_sel;
        logic [XLEN-1:0]     alu_result;
        logic [XLEN-1:0]     src2;
        logic [OFFSET_W-1:0] offset;
    } wb_entry_t;

endpackage

//--- source/data_port_if.sv
`timescale 1ns/1ps

interface data_port_if
    import mem_stage_pkg::*;
#(
    parameter int RAM_ADDR_BITS = 10
) ();

    // one access per cycle, qualified by en
    logic                     en;
    logic                     we;
    // word index, byte offset already stripped
    logic [RAM_ADDR_BITS-1:0] addr;
    logic [XLEN-1:0]          wdata;
    logic [STRB_W-1:0]        wstrb;
    // registered read word
    logic [XLEN-1:0]          rdata;

    // aligner side
    modport requester (
        output en, we, addr, wdata, wstrb,
        input  rdata
    );

    // ram side
    modport memory (
        input  en, we, addr, wdata, wstrb,
        output rdata
    );

endinterface

//--- source/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    // upstream side
    input  logic     up_valid,
    output logic     up_ready,
    input  payload_t up_data,
    // downstream side
    output logic     down_valid,
    input  logic     down_ready,
    output payload_t down_data
);

    logic     valid_q;
    payload_t data_q;

    // room when empty or when the current entry leaves this cycle
    assign up_ready = !valid_q || down_ready;

    // valid bit, the only control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (up_ready) begin
            // refill or drain in the same edge
            valid_q <= up_valid;
        end
    end

    // payload only moves on an upstream transfer
    always_ff @(posedge clk) begin
        if (up_valid && up_ready) begin
            data_q <= up_data;
        end
    end

    assign down_valid = valid_q;
    assign down_data  = data_q;

endmodule

//--- source/store_align.sv
`timescale 1ns/1ps

module store_align
    import mem_stage_pkg::*;
#(
    parameter int RAM_ADDR_BITS = 10
) (
    input  ex_entry_t          entry,
    // entry moves into the second step this edge
    input  logic               fire,
    data_port_if.requester     port
);

    logic [OFFSET_W-1:0] offset;
    logic                is_store;
    logic [STRB_W-1:0]   size_strb;
    logic [XLEN-1:0]     size_mask;

    // ******************************************************************
    // address split
    // ******************************************************************

    // low bits pick the lane, next bits the word
    assign offset    = entry.alu_result[OFFSET_W-1:0];
    // upper address bits dropped, index wraps
    assign port.addr = entry.alu_result[OFFSET_W +: RAM_ADDR_BITS];

    // ******************************************************************
    // operation decode
    // ******************************************************************

    always_comb begin
        is_store  = 1'b0;
        size_strb = '0;
        case (entry.op)
            // byte accesses
            MEM_LB, MEM_LBU: size_strb = 8'h01;
            MEM_SB: begin
                size_strb = 8'h01;
                is_store  = 1'b1;
            end
            // half word
            MEM_LH, MEM_LHU: size_strb = 8'h03;
            MEM_SH: begin
                size_strb = 8'h03;
                is_store  = 1'b1;
            end
            // word
            MEM_LW, MEM_LWU: size_strb = 8'h0f;
            MEM_SW: begin
                size_strb = 8'h0f;
                is_store  = 1'b1;
            end
            // double word
            MEM_LD: size_strb = 8'hff;
            MEM_SD: begin
                size_strb = 8'hff;
                is_store  = 1'b1;
            end
            default: begin
                size_strb = '0;
                is_store  = 1'b0;
            end
        endcase
    end

    // expand strobes into a bit mask over the low lanes
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            size_mask[b*BYTE_W +: BYTE_W] = {BYTE_W{size_strb[b]}};
        end
    end

    // ******************************************************************
    // request
    // ******************************************************************

    // no access for plain alu / csr traffic
    assign port.en    = fire && (entry.op != MEM_NONE);
    assign port.we    = is_store;
    // keep only the stored bytes, move them up to the lane
    assign port.wdata = (entry.src2 & size_mask) << {offset, 3'b000};
    assign port.wstrb = is_store ? (size_strb << offset) : '0;

endmodule

//--- source/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import mem_stage_pkg::*;
#(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic           clk,
    data_port_if.memory    port
);

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    // word array, no reset
    logic [XLEN-1:0] mem [DEPTH];
    logic [XLEN-1:0] rdata_q;

    // ******************************************************************
    // write and read port
    // ******************************************************************

    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.we) begin
                // per-lane write enables
                for (int b = 0; b < STRB_W; b++) begin
                    if (port.wstrb[b]) begin
                        mem[port.addr][b*BYTE_W +: BYTE_W] <= port.wdata[b*BYTE_W +: BYTE_W];
                    end
                end
            end else begin
                // read word captured only on enabled loads
                rdata_q <= mem[port.addr];
            end
        end
    end

    // holds while en is low
    // stalled load keeps its word
    assign port.rdata = rdata_q;

endmodule

//--- source/writeback_unit.sv
`timescale 1ns/1ps

module writeback_unit
    import mem_stage_pkg::*;
(
    input  wb_entry_t            entry,
    input  logic                 valid,
    // word read on the edge that loaded entry
    input  logic [XLEN-1:0]      rdata,
    output logic                 reg_wen,
    output logic [REG_ID_W-1:0]  reg_rd,
    output logic [XLEN-1:0]      reg_value
);

    logic [XLEN-1:0] lane_data;
    logic [XLEN-1:0] load_value;

    // ******************************************************************
    // load extraction
    // ******************************************************************

    // addressed lane down to bit 0
    assign lane_data = rdata >> {entry.offset, 3'b000};

    always_comb begin
        case (entry.op)
            // signed forms
            MEM_LB:  load_value = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
            MEM_LH:  load_value = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
            MEM_LW:  load_value = {{(XLEN-32){lane_data[31]}}, lane_data[31:0]};
            // unsigned forms
            MEM_LBU: load_value = {{(XLEN-8){1'b0}}, lane_data[7:0]};
            MEM_LHU: load_value = {{(XLEN-16){1'b0}}, lane_data[15:0]};
            MEM_LWU: load_value = {{(XLEN-32){1'b0}}, lane_data[31:0]};
            // full word, offset is zero
            MEM_LD:  load_value = rdata;
            // stores and none give nothing to write back
            default: load_value = '0;
        endcase
    end

    // ******************************************************************
    // write-back select
    // ******************************************************************

    always_comb begin
        case (entry.wb_sel)
            WB_ALU:  reg_value = entry.alu_result;
            // return address for jal / jalr
            WB_LINK: reg_value = entry.pc + LINK_STEP;
            WB_LOAD: reg_value = load_value;
            // csr read value rides in src2
            WB_CSR:  reg_value = entry.src2;
            default: reg_value = '0;
        endcase
    end

    // rd field of the instruction
    assign reg_rd  = entry.inst[11:7];
    // no write for stores, branches and empty slots
    assign reg_wen = valid && (entry.wb_sel != WB_NONE);

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top
    import mem_stage_pkg::*;
#(
    parameter int RAM_ADDR_BITS = 10
) (
    input  logic                clk,
    input  logic                rst,
    // from execute
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [XLEN-1:0]     in_pc,
    input  logic [31:0]         in_inst,
    input  mem_op_t             in_op,
    input  wb_sel_t             in_wb_sel,
    input  logic [XLEN-1:0]     in_alu_result,
    input  logic [XLEN-1:0]     in_src2,
    // to write-back
    output logic                out_valid,
    input  logic                out_ready,
    output logic [XLEN-1:0]     out_pc,
    output logic [31:0]         out_inst,
    output logic                reg_wen,
    output logic [REG_ID_W-1:0] reg_rd,
    output logic [XLEN-1:0]     reg_value
);

    ex_entry_t in_entry;
    ex_entry_t ex_q;
    logic      ex_valid;
    logic      wb_ready;
    logic      fire;
    wb_entry_t wb_d;
    wb_entry_t wb_q;

    data_port_if #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) dport ();

    // ******************************************************************
    // step one
    // ******************************************************************

    assign in_entry.pc         = in_pc;
    assign in_entry.inst       = in_inst;
    assign in_entry.op         = in_op;
    assign in_entry.wb_sel     = in_wb_sel;
    assign in_entry.alu_result = in_alu_result;
    assign in_entry.src2       = in_src2;

    stage_reg #(.payload_t(ex_entry_t)) ex_reg (
        .clk        (clk),
        .rst        (rst),
        .up_valid   (in_valid),
        .up_ready   (in_ready),
        .up_data    (in_entry),
        .down_valid (ex_valid),
        .down_ready (wb_ready),
        .down_data  (ex_q)
    );

    // advance into step two
    // ram access issued on this same edge
    assign fire = ex_valid && wb_ready;

    store_align #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_store_align (
        .entry (ex_q),
        .fire  (fire),
        .port  (dport.requester)
    );

    data_ram #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_data_ram (
        .clk  (clk),
        .port (dport.memory)
    );

    // ******************************************************************
    // step two
    // ******************************************************************

    // carry the lane offset for load extraction
    assign wb_d.pc         = ex_q.pc;
    assign wb_d.inst       = ex_q.inst;
    assign wb_d.op         = ex_q.op;
    assign wb_d.wb_sel     = ex_q.wb_sel;
    assign wb_d.alu_result = ex_q.alu_result;
    assign wb_d.src2       = ex_q.src2;
    assign wb_d.offset     = ex_q.alu_result[OFFSET_W-1:0];

    stage_reg #(.payload_t(wb_entry_t)) wb_reg (
        .clk        (clk),
        .rst        (rst),
        .up_valid   (ex_valid),
        .up_ready   (wb_ready),
        .up_data    (wb_d),
        .down_valid (out_valid),
        .down_ready (out_ready),
        .down_data  (wb_q)
    );

    writeback_unit u_writeback_unit (
        .entry     (wb_q),
        .valid     (out_valid),
        .rdata     (dport.rdata),
        .reg_wen   (reg_wen),
        .reg_rd    (reg_rd),
        .reg_value (reg_value)
    );

    // pass-through to write-back
    assign out_pc   = wb_q.pc;
    assign out_inst = wb_q.inst;

endmodule

//--- verif/mem_stage_properties.sv
`timescale 1ns/1ps

module mem_stage_properties
    import mem_stage_pkg::*;
(
    input logic                clk,
    input logic                rst,
    input logic                out_valid,
    input logic                out_ready,
    input logic [XLEN-1:0]     out_pc,
    input logic [31:0]         out_inst,
    input logic                reg_wen,
    input logic [REG_ID_W-1:0] reg_rd,
    input logic [XLEN-1:0]     reg_value
);

    // failures seen so far, read by the testbench at the end
    int fails = 0;

    // ******************************************************************
    // write-back port
    // ******************************************************************

    // stalled beat stays put, load data included
    hold_under_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pc) && $stable(out_inst)
            && $stable(reg_wen) && $stable(reg_rd) && $stable(reg_value))
        else begin
            $error("write-back beat changed while out_ready was low");
            fails++;
        end

    // no register write from an empty slot
    wen_needs_valid: assert property (@(posedge clk) disable iff (rst)
        reg_wen |-> out_valid)
        else begin
            $error("reg_wen high without out_valid");
            fails++;
        end

    empty_after_reset: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset");
            fails++;
        end

endmodule

bind mem_stage_top mem_stage_properties props0 (.*);

//--- verif/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb
    import mem_stage_pkg::*;
();

    localparam int RAM_BITS = 6;
    localparam int TIMEOUT  = 200;

    // one expected write-back beat
    typedef struct packed {
        logic [XLEN-1:0]     pc;
        logic [31:0]         inst;
        logic                wen;
        logic [REG_ID_W-1:0] rd;
        logic [XLEN-1:0]     value;
    } expect_t;

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic [XLEN-1:0]     in_pc;
    logic [31:0]         in_inst;
    mem_op_t             in_op;
    wb_sel_t             in_wb_sel;
    logic [XLEN-1:0]     in_alu_result;
    logic [XLEN-1:0]     in_src2;
    logic                out_valid;
    logic                out_ready = 1'b1;
    logic [XLEN-1:0]     out_pc;
    logic [31:0]         out_inst;
    logic                reg_wen;
    logic [REG_ID_W-1:0] reg_rd;
    logic [XLEN-1:0]     reg_value;

    // reference model state
    expect_t         exp_q [$];
    logic [XLEN-1:0] model_mem [1 << RAM_BITS];
    logic [31:0]     rng = 32'h09da_74fe;
    logic [31:0]     ready_rng = 32'h09da_74fe ^ 32'h5555_aaaa;
    logic            stall_en = 1'b0;
    logic            gap_en = 1'b0;
    int              checks = 0;
    int              errors = 0;
    int              test_err = 0;

    mem_stage_top #(.RAM_ADDR_BITS(RAM_BITS)) dut0 (.*);

    always #20 clk = ~clk;

    // ******************************************************************
    // random numbers and model
    // ******************************************************************

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    // access size in bytes
    function automatic int op_bytes(input mem_op_t op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 1;
            MEM_LH, MEM_LHU, MEM_SH: return 2;
            MEM_LW, MEM_LWU, MEM_SW: return 4;
            default:                 return 8;
        endcase
    endfunction

    // write-back source for an instruction without memory access
    function automatic wb_sel_t plain_sel(input logic [1:0] r);
        case (r)
            2'd0:    return WB_NONE;
            2'd1:    return WB_ALU;
            2'd2:    return WB_LINK;
            default: return WB_CSR;
        endcase
    endfunction

    // runs on every input transfer, stage keeps order
    task automatic accept_input();
        expect_t             e;
        logic [RAM_BITS-1:0] idx;
        int                  off;
        int                  n;
        logic [XLEN-1:0]     ld;
        idx = in_alu_result[OFFSET_W +: RAM_BITS];
        off = int'(in_alu_result[OFFSET_W-1:0]);
        n   = op_bytes(in_op);
        ld  = '0;
        // gather bytes upward from the offset
        for (int b = 0; b < n; b++) begin
            ld[b*8 +: 8] = model_mem[idx][(off+b)*8 +: 8];
        end
        if ((in_op == MEM_LB || in_op == MEM_LH || in_op == MEM_LW) && ld[n*8-1]) begin
            ld = ld | ~((64'd1 << (n*8)) - 64'd1);
        end
        if (in_op >= MEM_SB) begin
            for (int b = 0; b < n; b++) begin
                model_mem[idx][(off+b)*8 +: 8] = in_src2[b*8 +: 8];
            end
        end
        e.pc   = in_pc;
        e.inst = in_inst;
        e.rd   = in_inst[11:7];
        e.wen  = (in_wb_sel != WB_NONE);
        case (in_wb_sel)
            WB_ALU:  e.value = in_alu_result;
            WB_LINK: e.value = in_pc + 64'd4;
            WB_LOAD: e.value = ld;
            WB_CSR:  e.value = in_src2;
            default: e.value = '0;
        endcase
        exp_q.push_back(e);
    endtask

    // ******************************************************************
    // checks
    // ******************************************************************

    task automatic expect_value(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] want);
        checks++;
        assert (got === want) else begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    task automatic match_output();
        expect_t e;
        assert (exp_q.size() > 0) else begin
            $display("output beat appeared with no accepted instruction left");
            errors++;
        end
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            expect_value("out_pc", out_pc, e.pc);
            expect_value("out_inst", 64'(out_inst), 64'(e.inst));
            expect_value("reg_wen", 64'(reg_wen), 64'(e.wen));
            expect_value("reg_rd", 64'(reg_rd), 64'(e.rd));
            expect_value("reg_value", reg_value, e.value);
        end
    endtask

    // both handshakes sampled before the edge updates anything
    always @(posedge clk) begin
        if (!rst && in_valid && in_ready) begin
            accept_input();
        end
        if (!rst && out_valid && out_ready) begin
            match_output();
        end
    end

    // random back-pressure, about one cycle in four
    always @(negedge clk) begin
        if (stall_en) begin
            ready_rng = xorshift(ready_rng);
            out_ready = ready_rng[0] | ready_rng[3];
        end else begin
            out_ready = 1'b1;
        end
    end

    // ******************************************************************
    // stimulus
    // ******************************************************************

    task automatic report_timeout(input string why);
        $display("timeout: %s", why);
        errors++;
    endtask

    task automatic send_inst(input mem_op_t op, input wb_sel_t sel,
                             input logic [XLEN-1:0] alu, input logic [XLEN-1:0] src2);
        int waited;
        bit taken;
        waited = gap_en ? int'(rand32() % 3) : 0;
        @(negedge clk);
        // idle cycles before the next instruction
        repeat (waited) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_pc         = {rand32(), rand32()};
        in_inst       = rand32();
        in_op         = op;
        in_wb_sel     = sel;
        in_alu_result = alu;
        in_src2       = src2;
        in_valid      = 1'b1;
        waited        = 0;
        taken         = 1'b0;
        while (!taken && waited < TIMEOUT) begin
            @(posedge clk);
            taken = in_ready;
            waited++;
        end
        if (!taken) begin
            report_timeout("in_ready never came back for a pending instruction");
        end
    endtask

    // aligned access of random size to one ram word
    task automatic send_mem(input bit is_store, input logic [RAM_BITS-1:0] idx);
        logic [31:0]     r;
        mem_op_t         op;
        logic [XLEN-1:0] alu;
        r = rand32();
        if (is_store) begin
            op = mem_op_t'({2'b10, r[1:0]});
        end else begin
            op = mem_op_t'((r[2:0] == 3'd0) ? 4'd4 : {1'b0, r[2:0]});
        end
        // upper bits random, index wraps in the ram
        alu = {rand32(), rand32()};
        alu[OFFSET_W +: RAM_BITS] = idx;
        alu[OFFSET_W-1:0] = r[6:4] & ~3'(op_bytes(op) - 1);
        send_inst(op, is_store ? WB_NONE : WB_LOAD, alu, {rand32(), rand32()});
    endtask

    // drain the pipeline, then one line per test
    task automatic finish_test(input string name);
        int waited;
        @(negedge clk);
        in_valid = 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_timeout($sformatf("pipeline did not drain in test %s", name));
        end
        $display("test %s: %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    initial begin
        logic [XLEN-1:0] alu;
        logic [31:0]     r;
        wb_sel_t         sel;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_pc         = '0;
        in_inst       = '0;
        in_op         = MEM_NONE;
        in_wb_sel     = WB_NONE;
        in_alu_result = '0;
        in_src2       = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle pipeline after reset
        expect_value("out_valid", 64'(out_valid), 64'd0);
        expect_value("reg_wen", 64'(reg_wen), 64'd0);
        expect_value("in_ready", 64'(in_ready), 64'd1);
        finish_test("reset state");

        // alu, link and csr write-back
        for (int i = 0; i < 15; i++) begin
            sel = (i % 3 == 0) ? WB_ALU : ((i % 3 == 1) ? WB_LINK : WB_CSR);
            send_inst(MEM_NONE, sel, {rand32(), rand32()}, {rand32(), rand32()});
        end
        finish_test("alu link csr");

        // every word written once, then mixed sizes on a few words
        for (int w = 0; w < (1 << RAM_BITS); w++) begin
            alu = {rand32(), rand32()};
            alu[OFFSET_W +: RAM_BITS] = RAM_BITS'(w);
            alu[OFFSET_W-1:0] = '0;
            send_inst(MEM_SD, WB_NONE, alu, {rand32(), rand32()});
        end
        for (int i = 0; i < 40; i++) begin
            send_mem(1'b1, RAM_BITS'(rand32() % 8));
        end
        for (int i = 0; i < 60; i++) begin
            send_mem(1'b0, RAM_BITS'(rand32() % 8));
        end
        finish_test("stores then loads");

        // no register write expected
        for (int i = 0; i < 20; i++) begin
            r = rand32();
            if (r[0]) begin
                send_mem(1'b1, RAM_BITS'(rand32()));
            end else begin
                send_inst(MEM_NONE, WB_NONE, {rand32(), rand32()}, {rand32(), rand32()});
            end
        end
        finish_test("no write-back");

        // random mix with gaps and stalls
        gap_en   = 1'b1;
        stall_en = 1'b1;
        for (int i = 0; i < 150; i++) begin
            r = rand32();
            case (r[1:0])
                2'd1: send_mem(1'b1, RAM_BITS'(rand32()));
                2'd2: send_inst(MEM_NONE, plain_sel(2'(rand32())),
                                {rand32(), rand32()}, {rand32(), rand32()});
                default: send_mem(1'b0, RAM_BITS'(rand32()));
            endcase
        end
        finish_test("back-pressure");
        stall_en = 1'b0;
        gap_en   = 1'b0;

        // bound assertion failures count too
        errors = errors + dut0.props0.fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sources.f
source/mem_stage_pkg.sv
source/data_port_if.sv
source/stage_reg.sv
source/store_align.sv
source/data_ram.sv
source/writeback_unit.sv
source/mem_stage_top.sv
verif/mem_stage_properties.sv
verif/mem_stage_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = mem_stage_tb
FILELIST  = sources.f
RUNFLAGS  = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
